// File: compile.f
src/pcs_tx_pkg.sv
src/am_tx_ctrl.sv
src/am_bip_acc.sv
src/am_lane_tx.sv
src/am_tx.sv
verification/tb_clk_gen.sv
verification/am_tx_tb.sv

// File: Bender.yml
package:
  name: am_tx

dependencies: {}

sources:
  # design sources in compile order
  - src/pcs_tx_pkg.sv
  - src/am_tx_ctrl.sv
  - src/am_bip_acc.sv
  - src/am_lane_tx.sv
  - src/am_tx.sv

  # testbench
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/am_tx_tb.sv

// File: verification/am_tx_tb.sv
`default_nettype none

module am_tx_tb;

	localparam int unsigned LANE_N = 4;
	localparam int unsigned GAP_W  = 6;
	localparam int unsigned PERIOD = 1 << GAP_W;

	// run length in clock cycles for each phase of the test
	localparam int unsigned RESET_CYC     = 10;
	localparam int unsigned FIRST_RUN     = 3 * PERIOD + 30;
	localparam int unsigned MID_RESET_CYC = 3;
	localparam int unsigned SECOND_RUN    = 2 * PERIOD + 4;
	localparam int unsigned END_RESET_CYC = 2;
	localparam int unsigned TOTAL_CYC     = RESET_CYC + FIRST_RUN + MID_RESET_CYC
		+ SECOND_RUN + END_RESET_CYC;
	localparam int unsigned TIMEOUT_CYC   = TOTAL_CYC + 100;
	localparam int unsigned EXP_MARKERS   = FIRST_RUN / PERIOD + SECOND_RUN / PERIOD;

	logic                  clk;
	logic                  nreset;
	logic [LANE_N*2-1:0]   head_i;
	logic [LANE_N*64-1:0]  data_i;
	logic                  marker_v_o;
	logic [LANE_N*2-1:0]   head_o;
	logic [LANE_N*64-1:0]  data_o;

	integer                seed;
	int unsigned           check_cnt;
	int unsigned           error_cnt;
	int unsigned           marker_seen;
	int unsigned           cycle_cnt;

	// number of active edges since the last reset edge
	int unsigned           act_edges;
	logic                  reset_seen;

	// driven blocks wait here for comparison with the header in the top two bits
	logic [65:0]           blk_q [LANE_N][$];
	logic [7:0]            model_bip [LANE_N];

	tb_clk_gen #(
		.PERIOD (8)
	) clk_gen_inst (
		.clk_o (clk)
	);

	am_tx #(
		.LANE_N (LANE_N),
		.GAP_W  (GAP_W)
	) am_tx_inst (
		.clk        (clk),
		.nreset     (nreset),
		.head_i     (head_i),
		.data_i     (data_i),
		.marker_v_o (marker_v_o),
		.head_o     (head_o),
		.data_o     (data_o)
	);

	// fixed marker bytes M2 M1 M0 of each lane with M0 in the low byte
	function automatic logic [23:0] am_bytes_for_lane(input int unsigned lane);
		logic [23:0] enc;
		case (lane)
			0:       enc = {8'h47, 8'h76, 8'h90};
			1:       enc = {8'he6, 8'hc4, 8'hf0};
			2:       enc = {8'h9b, 8'h65, 8'hc5};
			default: enc = {8'h3d, 8'h79, 8'ha2};
		endcase
		return enc;
	endfunction

	// bit k of the parity byte collects every eighth data bit of the block
	function automatic logic [7:0] block_bip(input logic [1:0] head,
		input logic [63:0] data);
		logic [7:0] bip;
		int         k;
		int         j;
		bip = 8'h00;
		for (k = 0; k < 8; k++) begin
			for (j = 0; j < 8; j++) begin
				bip[k] = bip[k] ^ data[j*8+k];
			end
		end
		bip[3] = bip[3] ^ head[0];
		bip[4] = bip[4] ^ head[1];
		return bip;
	endfunction

	// expected marker payload for a lane given the model parity
	function automatic logic [63:0] marker_block(input int unsigned lane,
		input logic [7:0] bip);
		logic [63:0] blk;
		logic [23:0] enc;
		enc         = am_bytes_for_lane(lane);
		blk[23:0]   = enc;
		blk[31:24]  = bip;
		blk[55:32]  = ~enc;
		blk[63:56]  = ~bip;
		return blk;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		check_cnt++;
		if (exp !== act) begin
			error_cnt++;
			$display("Error at time %0t: %s expected 0x%0h actual 0x%0h",
				$time, name, exp, act);
		end
	endtask

	// a new random block goes to every lane and is queued only when the DUT will take it
	task automatic load_random_blocks(input logic record);
		logic [31:0] word;
		logic [1:0]  head;
		logic [63:0] data;
		int unsigned lane;
		for (lane = 0; lane < LANE_N; lane++) begin
			word         = $random(seed);
			head         = word[1:0];
			data[63:32]  = $random(seed);
			data[31:0]   = $random(seed);
			head_i[lane*2 +: 2]   = head;
			data_i[lane*64 +: 64] = data;
			if (record) begin
				blk_q[lane].push_back({head, data});
			end
		end
	endtask

	task automatic drive_blocks(input int unsigned count);
		int unsigned i;
		for (i = 0; i < count; i++) begin
			nreset = 1'b0;
			load_random_blocks(1'b1);
			@(negedge clk);
		end
	endtask

	// inputs keep changing during reset and must be ignored
	task automatic hold_reset(input int unsigned count);
		int unsigned i;
		for (i = 0; i < count; i++) begin
			nreset = 1'b1;
			load_random_blocks(1'b0);
			@(negedge clk);
		end
	endtask

	// compares the outputs registered on active edge k lane by lane
	task automatic compare_lanes(input int unsigned k);
		logic        marker_exp;
		logic [65:0] blk;
		logic [1:0]  head_exp;
		logic [63:0] data_exp;
		int unsigned lane;
		marker_exp = ((k % PERIOD) == 0);
		check_value("marker_v_o", marker_exp, marker_v_o);
		if (marker_v_o === 1'b1) begin
			marker_seen++;
		end
		for (lane = 0; lane < LANE_N; lane++) begin
			if (blk_q[lane].size() == 0) begin
				error_cnt++;
				$display("no driven block was left to compare on lane %0d at time %0t",
					lane, $time);
			end else begin
				blk = blk_q[lane].pop_front();
				if (marker_exp) begin
					head_exp        = 2'b10;
					data_exp        = marker_block(lane, model_bip[lane]);
					// a marker opens the next parity period
					model_bip[lane] = block_bip(head_exp, data_exp);
				end else begin
					head_exp        = blk[65:64];
					data_exp        = blk[63:0];
					model_bip[lane] = model_bip[lane] ^ block_bip(head_exp, data_exp);
				end
				check_value($sformatf("head_o lane %0d", lane), head_exp,
					head_o[lane*2 +: 2]);
				check_value($sformatf("data_o lane %0d", lane), data_exp,
					data_o[lane*64 +: 64]);
			end
		end
	endtask

	task automatic expect_idle_outputs();
		int unsigned lane;
		check_value("marker_v_o", 1'b0, marker_v_o);
		for (lane = 0; lane < LANE_N; lane++) begin
			check_value($sformatf("head_o lane %0d", lane), 2'b00, head_o[lane*2 +: 2]);
			check_value($sformatf("data_o lane %0d", lane), 64'h0, data_o[lane*64 +: 64]);
		end
	endtask

	// outputs seen at a rising edge were registered on the edge before
	always @(posedge clk) begin
		if (act_edges > 0) begin
			compare_lanes(act_edges);
		end else if (reset_seen) begin
			expect_idle_outputs();
		end
		if (nreset) begin
			reset_seen = 1'b1;
			act_edges  = 0;
			for (int unsigned lane = 0; lane < LANE_N; lane++) begin
				model_bip[lane] = 8'h00;
			end
		end else begin
			act_edges++;
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		seed        = 32'h7bd5;
		check_cnt   = 0;
		error_cnt   = 0;
		marker_seen = 0;
		act_edges   = 0;
		reset_seen  = 1'b0;
		nreset      = 1'b1;
		head_i      = '0;
		data_i      = '0;
		for (int unsigned lane = 0; lane < LANE_N; lane++) begin
			model_bip[lane] = 8'h00;
		end

		// the first reset edge uses the values set above
		@(posedge clk);
		@(negedge clk);
		hold_reset(RESET_CYC - 1);

		drive_blocks(FIRST_RUN);
		// second reset lands in the middle of a marker period
		hold_reset(MID_RESET_CYC);
		drive_blocks(SECOND_RUN);
		hold_reset(END_RESET_CYC);

		check_value("marker_v_o pulse count", EXP_MARKERS, marker_seen);

		$display("checks: %0d, errors: %0d", check_cnt, error_cnt);
		if (error_cnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
	parameter int unsigned PERIOD = 8
)(
	output logic clk_o
);

	localparam int unsigned HALF = PERIOD / 2;

	// free running clock, low for the first half period
	initial begin
		clk_o = 1'b0;
		forever begin
			#(HALF) clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

// File: src/am_tx.sv
`default_nettype none

module am_tx #(
	parameter int unsigned LANE_N = 4,
	parameter int unsigned GAP_W  = 14
)(
	input  wire logic                                    clk,
	input  wire logic                                    nreset,

	// lane 0 occupies the low bits of each bus
	input  wire logic [LANE_N*pcs_tx_pkg::HEAD_W-1:0]    head_i,
	input  wire logic [LANE_N*pcs_tx_pkg::DATA_W-1:0]    data_i,

	output logic                                         marker_v_o,
	output logic [LANE_N*pcs_tx_pkg::HEAD_W-1:0]         head_o,
	output logic [LANE_N*pcs_tx_pkg::DATA_W-1:0]         data_o
);

	localparam int unsigned HEAD_W = pcs_tx_pkg::HEAD_W;
	localparam int unsigned DATA_W = pcs_tx_pkg::DATA_W;

	// there are only four marker encodings to hand out
	if (LANE_N > pcs_tx_pkg::LANE_MAX) begin : g_lane_check
		$error("am_tx: LANE_N %0d exceeds the %0d lanes with marker encodings",
			LANE_N, pcs_tx_pkg::LANE_MAX);
	end

	// single insertion request shared by every lane,
	// so all lanes carry their marker in the same cycle
	logic insert;

	am_tx_ctrl #(
		.GAP_W (GAP_W)
	) m_ctrl (
		.clk        (clk),
		.nreset     (nreset),
		.insert_o   (insert),
		.marker_v_o (marker_v_o)
	);

	for (genvar lane = 0; lane < LANE_N; lane++) begin : g_lane
		am_lane_tx #(
			.LANE_ENC (pcs_tx_pkg::AM_ENC[lane])
		) m_lane (
			.clk      (clk),
			.nreset   (nreset),
			.insert_i (insert),
			.head_i   (head_i[lane*HEAD_W +: HEAD_W]),
			.data_i   (data_i[lane*DATA_W +: DATA_W]),
			.head_o   (head_o[lane*HEAD_W +: HEAD_W]),
			.data_o   (data_o[lane*DATA_W +: DATA_W])
		);
	end

endmodule

`default_nettype wire

// File: src/am_lane_tx.sv
`default_nettype none

module am_lane_tx #(
	parameter pcs_tx_pkg::am_bytes_t LANE_ENC = pcs_tx_pkg::AM_ENC[0]
)(
	input  wire logic                    clk,
	input  wire logic                    nreset,

	input  wire logic                    insert_i,

	input  wire pcs_tx_pkg::sync_hdr_t   head_i,
	input  wire pcs_tx_pkg::block_data_t data_i,

	output pcs_tx_pkg::sync_hdr_t        head_o,
	output pcs_tx_pkg::block_data_t      data_o
);

	pcs_tx_pkg::bip_t        bip3;
	pcs_tx_pkg::bip_t        bip7;
	pcs_tx_pkg::block_data_t marker_data;

	pcs_tx_pkg::sync_hdr_t   head_q;
	pcs_tx_pkg::block_data_t data_q;
	logic                    marker_q;

	// BIP7 is just the complement of BIP3
	assign bip7 = ~bip3;

	// byte 0 is the lowest byte of the payload
	// from the top the layout is BIP7 then ~M2 ~M1 ~M0 then BIP3 and M2 M1 M0
	assign marker_data = {bip7, ~LANE_ENC, bip3, LANE_ENC};

	always_ff @(posedge clk) begin
		if (nreset) begin
			head_q   <= '0;
			data_q   <= '0;
			marker_q <= 1'b0;
		end else begin
			marker_q <= insert_i;
			if (insert_i) begin
				// the incoming block is dropped and the marker takes its slot
				head_q <= pcs_tx_pkg::AM_SYNC_HDR;
				data_q <= marker_data;
			end else begin
				head_q <= head_i;
				data_q <= data_i;
			end
		end
	end

	// parity runs over what actually leaves the lane including the markers
	am_bip_acc m_bip_acc (
		.clk       (clk),
		.nreset    (nreset),
		.head_i    (head_q),
		.data_i    (data_q),
		.restart_i (marker_q),
		.bip_o     (bip3)
	);

	assign head_o = head_q;
	assign data_o = data_q;

	// a marker on the output carries BIP7 as the complement of BIP3
	a_marker_bip7 : assert property (
		@(posedge clk) disable iff (nreset)
		marker_q |-> (data_o[63:56] == ~data_o[31:24])
	);

endmodule

`default_nettype wire

// File: src/am_bip_acc.sv
`default_nettype none

module am_bip_acc (
	input  wire logic                    clk,
	input  wire logic                    nreset,

	input  wire pcs_tx_pkg::sync_hdr_t   head_i,
	input  wire pcs_tx_pkg::block_data_t data_i,
	input  wire logic                    restart_i,

	output pcs_tx_pkg::bip_t             bip_o
);

	// parity contribution of one block
	// bit k of the result is the XOR of payload bits k, k+8 up to k+56,
	// the sync header bits are folded into bits 3 and 4
	function automatic pcs_tx_pkg::bip_t bip_fold(
		input pcs_tx_pkg::sync_hdr_t   head,
		input pcs_tx_pkg::block_data_t data
	);
		pcs_tx_pkg::bip_t bip;
		int unsigned      byte_idx;
		bip = '0;
		for (byte_idx = 0; byte_idx < pcs_tx_pkg::DATA_W / 8; byte_idx++) begin
			bip ^= data[byte_idx*8 +: 8];
		end
		bip[3] ^= head[0];
		bip[4] ^= head[1];
		return bip;
	endfunction

	pcs_tx_pkg::bip_t blk_bip;
	pcs_tx_pkg::bip_t acc_q;
	pcs_tx_pkg::bip_t acc_next;

	assign blk_bip = bip_fold(head_i, data_i);

	// a marker opens a new period, so its own parity is the new base
	assign acc_next = restart_i ? blk_bip : (acc_q ^ blk_bip);

	always_ff @(posedge clk) begin
		if (nreset) begin
			acc_q <= '0;
		end else begin
			acc_q <= acc_next;
		end
	end

	// the running value already includes the block on the input,
	// which is the last one on the wire before the next marker
	assign bip_o = acc_next;

endmodule

`default_nettype wire

// File: src/am_tx_ctrl.sv
`default_nettype none

module am_tx_ctrl #(
	parameter int unsigned GAP_W = 14
)(
	input  wire logic clk,
	input  wire logic nreset,

	output logic      insert_o,
	output logic      marker_v_o
);

	// block counter, one step per clock
	// it restarts at 1 so that the marker slot is the wrap to zero
	logic [GAP_W-1:0] gap_q;
	logic [GAP_W-1:0] gap_next;
	logic             insert_next;
	logic             insert_q;
	logic             marker_v_q;

	assign gap_next = gap_q + {{(GAP_W-1){1'b0}}, 1'b1};

	// the counter is about to wrap, so the next cycle is the marker slot
	assign insert_next = &gap_q;

	always_ff @(posedge clk) begin
		if (nreset) begin
			gap_q      <= {{(GAP_W-1){1'b0}}, 1'b1};
			insert_q   <= 1'b0;
			marker_v_q <= 1'b0;
		end else begin
			gap_q      <= gap_next;
			insert_q   <= insert_next;
			// lanes register the marker on the same edge, so the strobe
			// lines up with the marker on the lane outputs
			marker_v_q <= insert_q;
		end
	end

	assign insert_o   = insert_q;
	assign marker_v_o = marker_v_q;

	// the insertion slot is the cycle where the counter sits at zero
	a_insert_at_wrap : assert property (
		@(posedge clk) disable iff (nreset)
		insert_o |-> (gap_q == '0)
	);

	// the strobe follows the insertion request by exactly one cycle
	a_marker_after_insert : assert property (
		@(posedge clk) disable iff (nreset)
		marker_v_o |-> $past(insert_o)
	);

	// only one block per period is replaced
	a_insert_single : assert property (
		@(posedge clk) disable iff (nreset)
		insert_o |=> !insert_o
	);

endmodule

`default_nettype wire

// File: src/pcs_tx_pkg.sv
`default_nettype none

package pcs_tx_pkg;

	// a 64b/66b block is a 2-bit sync header followed by 64 payload bits
	localparam int unsigned HEAD_W = 2;
	localparam int unsigned DATA_W = 64;

	// one bit-interleaved parity byte
	localparam int unsigned BIP_W = 8;

	// three fixed bytes M0, M1, M2 identify each lane inside a marker
	localparam int unsigned AM_W = 3 * 8;

	typedef logic [HEAD_W-1:0] sync_hdr_t;
	typedef logic [DATA_W-1:0] block_data_t;
	typedef logic [BIP_W-1:0]  bip_t;
	typedef logic [AM_W-1:0]   am_bytes_t;

	// marker encodings are only defined for this many lanes
	localparam int unsigned LANE_MAX = 4;

	// marker blocks always carry a control sync header
	localparam sync_hdr_t AM_SYNC_HDR = 2'b10;

	// fixed marker bytes per lane, M0 sits in the low byte
	// the full marker block is laid out as
	// M0 M1 M2 BIP3 ~M0 ~M1 ~M2 BIP7, byte 0 first on the wire
	localparam am_bytes_t AM_ENC [LANE_MAX] = '{
		24'h47_76_90,
		24'he6_c4_f0,
		24'h9b_65_c5,
		24'h3d_79_a2
	};

endpackage

`default_nettype wire
